// File: hw/fetch_consts.svh
// Fetch front-end sizing and reset constants; include in any file that needs a width or table size
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Address and data path width
`define XLEN 32

// Instruction width, sequential step is ILEN/8 bytes
`define ILEN 32

// Fetch address after reset
`define BOOT_PC 32'h0000_0100

// Direction counter table, 2**BHT_IDX_W entries
`define BHT_IDX_W 4

// Branch target buffer, 2**BTB_IDX_W entries
`define BTB_IDX_W 4

// Both tables index above the two byte-offset bits
`define IDX_LSB 2

`endif

// File: hw/fetch_pkg.sv
// Address, index, tag and counter types of the fetch front end, taken in by wildcard import
`include "fetch_consts.svh"

package fetch_pkg;

  // Fetch address or branch target
  typedef logic [`XLEN-1:0] xlen_t;

  // Direction counter table index
  typedef logic [`BHT_IDX_W-1:0] bht_idx_t;

  // Target buffer index, same address bits as the counter table
  typedef logic [`BTB_IDX_W-1:0] btb_idx_t;

  // Upper address bits kept as the buffer tag
  localparam int unsigned BTB_TAG_W = `XLEN - `BTB_IDX_W - `IDX_LSB;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  // 2-bit saturating counter, MSB set means taken
  typedef logic [1:0] bht_cnt_t;

  // Counter table index from a fetch or branch address
  function automatic bht_idx_t bht_index(xlen_t addr);
    return addr[`BHT_IDX_W+`IDX_LSB-1:`IDX_LSB];
  endfunction

  // Target buffer index, skips the byte offset
  function automatic btb_idx_t btb_index(xlen_t addr);
    return addr[`BTB_IDX_W+`IDX_LSB-1:`IDX_LSB];
  endfunction

  // Everything above the index is the tag
  function automatic btb_tag_t btb_tag(xlen_t addr);
    return addr[`XLEN-1:`BTB_IDX_W+`IDX_LSB];
  endfunction

endpackage

// File: hw/res_if.sv
// Branch resolution bundle from execute, fanned out to the PC stage and the predictor
`timescale 1ns/1ps

interface res_if
  import fetch_pkg::*;
();

  // One-cycle strobe, no acknowledge, always accepted
  logic  valid;
  // Predictor got this branch wrong
  logic  mispredict;
  // Actual branch outcome
  logic  taken;
  // Address of the resolved branch
  xlen_t pc;
  // Resolved branch destination
  xlen_t target;

  // Execute side
  modport drv (
    output valid,
    output mispredict,
    output taken,
    output pc,
    output target
  );

  // PC stage and predictor side
  modport rcv (
    input valid,
    input mispredict,
    input taken,
    input pc,
    input target
  );

endinterface

// File: hw/pc_gen_stage.sv
// Program counter of the fetch front end; picks the next fetch address and holds on stall
`timescale 1ns/1ps
`include "fetch_consts.svh"

module pc_gen_stage
  import fetch_pkg::*;
#(
  parameter xlen_t BOOT_PC = `BOOT_PC
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Exception redirect
  input  logic  except_i,
  input  xlen_t except_pc_i,
  // Branch resolution from execute
  res_if.rcv    res,
  // Prediction for the current pc_o
  input  logic  pred_taken_i,
  input  xlen_t pred_target_i,
  // Downstream can take a new address
  input  logic  fetch_ready_i,
  output xlen_t pc_o
);

  // Sequential step in bytes
  localparam xlen_t PC_INC = xlen_t'(`ILEN / 8);

  logic  recover;
  xlen_t add_base;
  xlen_t add_sum;
  xlen_t next_pc;

  // Valid mispredict needs a redirect
  assign recover = res.valid && res.mispredict;

  // Single adder shared by recovery and sequential fetch
  // Branch address on recovery, current pc otherwise
  assign add_base = recover ? res.pc : pc_o;
  assign add_sum  = add_base + PC_INC;

  // Next address, highest priority first
  always_comb begin
    if (except_i) begin
      // Exception handler address
      next_pc = except_pc_i;
    end else if (recover) begin
      // Resolved outcome wins over any prediction
      if (res.taken) begin
        next_pc = res.target;
      end else begin
        next_pc = add_sum;
      end
    end else if (pred_taken_i) begin
      // Predicted taken branch
      next_pc = pred_target_i;
    end else begin
      // Fall through, pc plus four
      next_pc = add_sum;
    end
  end

  // PC register, loads only when fetch is ready
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o <= BOOT_PC;
    end else if (fetch_ready_i) begin
      pc_o <= next_pc;
    end
  end

endmodule

// File: hw/btb.sv
// Direct-mapped branch target buffer; combinational lookup, filled by resolved taken branches
`timescale 1ns/1ps
`include "fetch_consts.svh"

module btb
  import fetch_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Lookup port, current fetch address
  input  xlen_t lookup_pc_i,
  output logic  hit_o,
  output xlen_t target_o,
  // Training from execute
  res_if.rcv    res
);

  localparam int unsigned ENTRIES = 2 ** `BTB_IDX_W;

  // Entry storage
  logic     valid_q  [ENTRIES];
  btb_tag_t tag_q    [ENTRIES];
  xlen_t    target_q [ENTRIES];

  // Lookup side
  btb_idx_t rd_idx;
  btb_tag_t rd_tag;

  // Write side
  logic     wr_en;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;

  // Split the fetch address into index and tag
  assign rd_idx = btb_index(lookup_pc_i);
  assign rd_tag = btb_tag(lookup_pc_i);

  // Hit needs a live entry with a matching tag
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  // Target is meaningful only with hit_o
  assign target_o = target_q[rd_idx];

  // Only taken branches are worth storing
  assign wr_en  = res.valid && res.taken;
  assign wr_idx = btb_index(res.pc);
  assign wr_tag = btb_tag(res.pc);

  // Valid bits, cleared on reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag and target payload
  // A new branch at the same index replaces the old one
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= res.target;
    end
  end

endmodule

// File: hw/bpu.sv
// Branch prediction unit; 2-bit direction counters plus target buffer, predicts from the fetch PC
`timescale 1ns/1ps
`include "fetch_consts.svh"

module bpu
  import fetch_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Current fetch address
  input  xlen_t pc_i,
  // Training from execute
  res_if.rcv    res,
  // Same-cycle prediction for pc_i
  output logic  pred_taken_o,
  output xlen_t pred_target_o
);

  localparam int unsigned ENTRIES = 2 ** `BHT_IDX_W;

  // Counter encodings
  localparam bht_cnt_t CNT_MIN     = 2'd0;
  localparam bht_cnt_t CNT_WEAK_NT = 2'd1;
  localparam bht_cnt_t CNT_MAX     = 2'd3;

  bht_cnt_t cnt_q [ENTRIES];

  bht_idx_t rd_idx;
  bht_idx_t wr_idx;
  bht_cnt_t wr_cnt;

  logic     btb_hit;
  xlen_t    btb_target;

  // Target lookup and fill
  btb u_btb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (pc_i),
    .hit_o       (btb_hit),
    .target_o    (btb_target),
    .res         (res)
  );

  assign rd_idx = bht_index(pc_i);
  assign wr_idx = bht_index(res.pc);
  assign wr_cnt = cnt_q[wr_idx];

  // Taken needs a known target and a taken-leaning counter
  assign pred_taken_o  = btb_hit && cnt_q[rd_idx][1];
  assign pred_target_o = btb_target;

  // Counter training on every resolved branch
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Everything starts weakly not taken
      for (int i = 0; i < ENTRIES; i++) begin
        cnt_q[i] <= CNT_WEAK_NT;
      end
    end else if (res.valid) begin
      if (res.taken) begin
        // Count up, stop at strongly taken
        if (wr_cnt != CNT_MAX) begin
          cnt_q[wr_idx] <= wr_cnt + 2'd1;
        end
      end else begin
        // Count down, stop at strongly not taken
        if (wr_cnt != CNT_MIN) begin
          cnt_q[wr_idx] <= wr_cnt - 2'd1;
        end
      end
    end
  end

endmodule

// File: hw/fetch_front_top.sv
// Fetch front-end top level; joins the PC stage and predictor behind plain ports
`timescale 1ns/1ps

module fetch_front_top
  import fetch_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Exception redirect
  input  logic  except_i,
  input  xlen_t except_pc_i,
  // Branch resolution from execute
  input  logic  res_valid_i,
  input  logic  res_mispredict_i,
  input  logic  res_taken_i,
  input  xlen_t res_pc_i,
  input  xlen_t res_target_i,
  // Fetch back-pressure
  input  logic  fetch_ready_i,
  // Fetch address and its prediction
  output xlen_t pc_o,
  output logic  pred_taken_o,
  output xlen_t pred_target_o
);

  // Resolution bundle shared by both blocks
  res_if res_bus ();

  // Pack the plain ports onto the driver side
  assign res_bus.valid      = res_valid_i;
  assign res_bus.mispredict = res_mispredict_i;
  assign res_bus.taken      = res_taken_i;
  assign res_bus.pc         = res_pc_i;
  assign res_bus.target     = res_target_i;

  // Address generation
  pc_gen_stage u_pc_gen (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .except_i      (except_i),
    .except_pc_i   (except_pc_i),
    .res           (res_bus.rcv),
    .pred_taken_i  (pred_taken_o),
    .pred_target_i (pred_target_o),
    .fetch_ready_i (fetch_ready_i),
    .pc_o          (pc_o)
  );

  // Prediction for the address just issued
  bpu u_bpu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .pc_i          (pc_o),
    .res           (res_bus.rcv),
    .pred_taken_o  (pred_taken_o),
    .pred_target_o (pred_target_o)
  );

endmodule

// File: verif/fetch_front_assert.sv
// Concurrent checks on the PC register that bind into every pc_gen_stage instance
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_front_assert
  import fetch_pkg::*;
#(
  parameter xlen_t BOOT_PC = `BOOT_PC
) (
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  except_i,
  input xlen_t except_pc_i,
  input logic  fetch_ready_i,
  input xlen_t pc_o
);

  // Failure counts of the three checks
  int unsigned boot_fails   = 0;
  int unsigned hold_fails   = 0;
  int unsigned except_fails = 0;

  // First edge out of reset still shows the boot address
  boot_value: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> (pc_o == BOOT_PC)
  ) else begin
    boot_fails++;
    $error("pc_o left reset at %h instead of %h", pc_o, BOOT_PC);
  end

  // Stalled fetch keeps the address
  stall_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !fetch_ready_i |=> $stable(pc_o)
  ) else begin
    hold_fails++;
    $error("pc_o changed while fetch was stalled");
  end

  // Exception beats mispredict and prediction
  except_load: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (except_i && fetch_ready_i) |=> (pc_o == $past(except_pc_i))
  ) else begin
    except_fails++;
    $error("pc_o %h did not follow the exception address", pc_o);
  end

endmodule

// Attach to the PC stage with the boot address from the instance parameter
bind pc_gen_stage fetch_front_assert #(
  .BOOT_PC (BOOT_PC)
) u_fetch_assert (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .except_i      (except_i),
  .except_pc_i   (except_pc_i),
  .fetch_ready_i (fetch_ready_i),
  .pc_o          (pc_o)
);

// File: verif/tb_fetch_front.sv
// Pattern-driven testbench for the fetch front end; run from the project root with tb.f
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch_front
  import fetch_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_PAT      = 64;
  localparam int NUM_FIELDS   = 11;
  localparam string PAT_FILE  = "verif/fetch_patterns.txt";

  // DUT inputs
  logic  clk_i;
  logic  rst_n_i;
  logic  except_i;
  xlen_t except_pc_i;
  logic  res_valid_i;
  logic  res_mispredict_i;
  logic  res_taken_i;
  xlen_t res_pc_i;
  xlen_t res_target_i;
  logic  fetch_ready_i;

  // DUT outputs
  xlen_t pc_o;
  logic  pred_taken_o;
  xlen_t pred_target_o;

  // Pattern storage with one entry per cycle
  logic  pat_except     [MAX_PAT];
  xlen_t pat_except_pc  [MAX_PAT];
  logic  pat_valid      [MAX_PAT];
  logic  pat_misp       [MAX_PAT];
  logic  pat_taken      [MAX_PAT];
  xlen_t pat_res_pc     [MAX_PAT];
  xlen_t pat_res_target [MAX_PAT];
  logic  pat_ready      [MAX_PAT];
  xlen_t pat_exp_pc     [MAX_PAT];
  logic  pat_exp_taken  [MAX_PAT];
  xlen_t pat_exp_target [MAX_PAT];
  // Source line of each pattern for error lines
  int    pat_line       [MAX_PAT];
  int    n_pat = 0;
  logic  load_ok = 1'b1;

  // Error counters
  int value_errors   = 0;
  int format_errors  = 0;
  int timeout_errors = 0;

  // Watchdog state
  int   cycle_cnt   = 0;
  int   cycle_limit = 0;
  logic limit_ready = 1'b0;

  fetch_front_top DUT (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .except_i         (except_i),
    .except_pc_i      (except_pc_i),
    .res_valid_i      (res_valid_i),
    .res_mispredict_i (res_mispredict_i),
    .res_taken_i      (res_taken_i),
    .res_pc_i         (res_pc_i),
    .res_target_i     (res_target_i),
    .fetch_ready_i    (fetch_ready_i),
    .pc_o             (pc_o),
    .pred_taken_o     (pred_taken_o),
    .pred_target_o    (pred_target_o)
  );

  // 20 ns clock
  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Read all pattern lines and skip comments and blank lines
  task automatic load_patterns();
    int    fd;
    int    cnt;
    int    line_no;
    string line;
    xlen_t fld [NUM_FIELDS];
    fd = $fopen(PAT_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open pattern file %s", PAT_FILE);
      format_errors++;
      load_ok = 1'b0;
    end else begin
      line_no = 0;
      while ($fgets(line, fd) != 0) begin
        line_no++;
        if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
          continue;
        end
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                      fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                      fld[6], fld[7], fld[8], fld[9], fld[10]);
        if (cnt != NUM_FIELDS) begin
          $display("Malformed pattern line %0d: expected %0d fields, found %0d",
                   line_no, NUM_FIELDS, cnt);
          format_errors++;
        end else if (n_pat == MAX_PAT) begin
          $display("Too many patterns, line %0d and later are ignored", line_no);
          format_errors++;
          break;
        end else begin
          pat_except[n_pat]     = fld[0][0];
          pat_except_pc[n_pat]  = fld[1];
          pat_valid[n_pat]      = fld[2][0];
          pat_misp[n_pat]       = fld[3][0];
          pat_taken[n_pat]      = fld[4][0];
          pat_res_pc[n_pat]     = fld[5];
          pat_res_target[n_pat] = fld[6];
          pat_ready[n_pat]      = fld[7][0];
          pat_exp_pc[n_pat]     = fld[8];
          pat_exp_taken[n_pat]  = fld[9][0];
          pat_exp_target[n_pat] = fld[10];
          pat_line[n_pat]       = line_no;
          n_pat++;
        end
      end
      $fclose(fd);
      if (n_pat == 0) begin
        $display("Pattern file %s holds no usable pattern lines", PAT_FILE);
        format_errors++;
        load_ok = 1'b0;
      end
    end
  endtask

  // Address check
  task automatic check_pc(input int line_no, input xlen_t exp_pc, input xlen_t act_pc);
    if (act_pc !== exp_pc) begin
      value_errors++;
      $display("CHECK FAILED line %0d: pc_o expected %h got %h", line_no, exp_pc, act_pc);
    end
  endtask

  // Prediction check where the target only matters on a taken prediction
  task automatic check_pred(input int line_no, input logic exp_taken, input xlen_t exp_target,
                            input logic act_taken, input xlen_t act_target);
    if (act_taken !== exp_taken) begin
      value_errors++;
      $display("CHECK FAILED line %0d: pred_taken_o expected %h got %h",
               line_no, exp_taken, act_taken);
    end else if (exp_taken && act_target !== exp_target) begin
      value_errors++;
      $display("CHECK FAILED line %0d: pred_target_o expected %h got %h",
               line_no, exp_target, act_target);
    end
  endtask

  // Drive one pattern's inputs at the current edge
  task automatic apply_pattern(input int i);
    except_i         <= pat_except[i];
    except_pc_i      <= pat_except_pc[i];
    res_valid_i      <= pat_valid[i];
    res_mispredict_i <= pat_misp[i];
    res_taken_i      <= pat_taken[i];
    res_pc_i         <= pat_res_pc[i];
    res_target_i     <= pat_res_target[i];
    fetch_ready_i    <= pat_ready[i];
  endtask

  // Quiet inputs with fetch stalled
  task automatic apply_idle();
    except_i         <= 1'b0;
    res_valid_i      <= 1'b0;
    res_mispredict_i <= 1'b0;
    res_taken_i      <= 1'b0;
    fetch_ready_i    <= 1'b0;
  endtask

  task automatic apply_reset();
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  // Pattern i is applied at one edge, taken by the DUT at the next,
  // and its outputs are sampled just before the edge after that
  task automatic run_patterns();
    for (int i = 0; i <= n_pat; i++) begin
      @(posedge clk_i);
      if (i < n_pat) begin
        apply_pattern(i);
      end else begin
        apply_idle();
      end
      #(CLK_PERIOD - 2);
      if (i == 0) begin
        // Boot state right after reset release
        check_pc(0, `BOOT_PC, pc_o);
        check_pred(0, 1'b0, '0, pred_taken_o, pred_target_o);
      end else begin
        check_pc(pat_line[i-1], pat_exp_pc[i-1], pc_o);
        check_pred(pat_line[i-1], pat_exp_taken[i-1], pat_exp_target[i-1],
                   pred_taken_o, pred_target_o);
      end
    end
  endtask

  // Counts line followed by the verdict
  task automatic finish_run();
    int assert_errors;
    assert_errors = DUT.u_pc_gen.u_fetch_assert.boot_fails
                  + DUT.u_pc_gen.u_fetch_assert.hold_fails
                  + DUT.u_pc_gen.u_fetch_assert.except_fails;
    $display("Errors: value %0d, pattern file %0d, timeout %0d, assertion %0d",
             value_errors, format_errors, timeout_errors, assert_errors);
    if (value_errors + format_errors + timeout_errors + assert_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // Main sequence
  initial begin
    rst_n_i          = 1'b0;
    except_i         = 1'b0;
    except_pc_i      = '0;
    res_valid_i      = 1'b0;
    res_mispredict_i = 1'b0;
    res_taken_i      = 1'b0;
    res_pc_i         = '0;
    res_target_i     = '0;
    fetch_ready_i    = 1'b0;
    load_patterns();
    cycle_limit = n_pat + RESET_CYCLES + 50;
    limit_ready = 1'b1;
    if (load_ok) begin
      apply_reset();
      run_patterns();
    end
    finish_run();
  end

  // Watchdog whose limit follows the pattern count
  initial begin
    wait (limit_ready);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run did not end within %0d clock cycles", cycle_limit);
    timeout_errors++;
    finish_run();
  end

endmodule

// File: verif/fetch_patterns.txt
# Columns (hex): except except_pc res_valid res_mispredict res_taken res_pc res_target
#   fetch_ready exp_pc exp_pred_taken exp_pred_target, one fetch cycle per line
# Sequential fetch from boot address
0 00000000 0 0 0 00000000 00000000 1 00000104 0 00000000
0 00000000 0 0 0 00000000 00000000 1 00000108 0 00000000
0 00000000 0 0 0 00000000 00000000 1 0000010c 0 00000000
# Stall then resume
0 00000000 0 0 0 00000000 00000000 0 0000010c 0 00000000
0 00000000 0 0 0 00000000 00000000 0 0000010c 0 00000000
0 00000000 0 0 0 00000000 00000000 0 0000010c 0 00000000
0 00000000 0 0 0 00000000 00000000 1 00000110 0 00000000
# Two taken resolutions of the branch at 0x120, then fetch reaches it
0 00000000 1 0 1 00000120 00000200 1 00000114 0 00000000
0 00000000 1 0 1 00000120 00000200 1 00000118 0 00000000
0 00000000 0 0 0 00000000 00000000 1 0000011c 0 00000000
0 00000000 0 0 0 00000000 00000000 1 00000120 1 00000200
0 00000000 0 0 0 00000000 00000000 1 00000200 0 00000000
# Mispredict recovery, taken and not taken, over a live prediction
0 00000000 1 1 1 00000300 00000120 1 00000120 1 00000200
0 00000000 1 1 1 000001f0 00000400 1 00000400 0 00000000
0 00000000 1 1 0 0000011c 00000000 1 00000120 1 00000200
0 00000000 1 1 0 00000240 00000000 1 00000244 0 00000000
# Exception over mispredict and taken prediction
0 00000000 1 1 0 0000011c 00000000 1 00000120 1 00000200
1 00000080 1 1 1 000001f0 00000400 1 00000080 0 00000000
0 00000000 0 0 0 00000000 00000000 1 00000084 0 00000000
# Counter hysteresis at 0x120, second update lands during a stall
0 00000000 1 0 0 00000120 00000000 1 00000088 0 00000000
1 00000120 0 0 0 00000000 00000000 1 00000120 1 00000200
0 00000000 1 0 0 00000120 00000000 0 00000120 0 00000000
0 00000000 0 0 0 00000000 00000000 1 00000124 0 00000000
# Alias 0x230 shares the index of 0x1f0 with another tag
1 00000230 0 0 0 00000000 00000000 1 00000230 0 00000000
0 00000000 0 0 0 00000000 00000000 1 00000234 0 00000000
1 000001f0 0 0 0 00000000 00000000 1 000001f0 1 00000400
0 00000000 0 0 0 00000000 00000000 1 00000400 0 00000000
0 00000000 0 0 0 00000000 00000000 1 00000404 0 00000000

// File: tb.f
+incdir+hw
hw/fetch_pkg.sv
hw/res_if.sv
hw/pc_gen_stage.sv
hw/btb.sv
hw/bpu.sv
hw/fetch_front_top.sv
verif/fetch_front_assert.sv
verif/tb_fetch_front.sv
